// ==== verilog/fu_pkg.sv ====
package fu_pkg;

	// floating-point unit classes sharing the write-back bus
	typedef enum logic [2:0] {
		FU_FDIV,
		FU_FADD,
		FU_FMUL,
		FU_ITOF,
		FU_LW
	} fu_unit_t;

	// cycles from issue accept to broadcast
	localparam int LAT_FDIV = 14;
	localparam int LAT_FADD = 6;
	localparam int LAT_FMUL = 4;
	localparam int LAT_ITOF = 3;
	localparam int LAT_LW   = 1;

	// one stage per cycle of the longest unit
	localparam int LINE_DEPTH  = LAT_FDIV;
	localparam int STAGE_WIDTH = $clog2(LINE_DEPTH);

	function automatic int fu_latency(fu_unit_t unit);
		case (unit)
			FU_FDIV: return LAT_FDIV;
			FU_FADD: return LAT_FADD;
			FU_FMUL: return LAT_FMUL;
			FU_ITOF: return LAT_ITOF;
			default: return LAT_LW;
		endcase
	endfunction

endpackage

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

	import fu_pkg::*;

	localparam int ROB_DEPTH  = 16;
	localparam int TAG_WIDTH  = 4;
	localparam int DATA_WIDTH = 32;

	typedef logic [TAG_WIDTH-1:0]  rob_tag_t;
	typedef logic [DATA_WIDTH-1:0] wb_data_t;

	// one booked write-back slot, 40 bits
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		fu_unit_t unit;
		wb_data_t data;
	} wb_slot_t;

endpackage

// ==== verilog/wb_issue_arbiter.sv ====
`timescale 1ns/1ps

module wb_issue_arbiter
	import fu_pkg::*;
	import rob_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue_valid,
	input  fu_unit_t               issue_unit,
	input  wb_data_t               issue_data,
	output logic                   issue_ready,
	input  logic [LINE_DEPTH-1:0]  occupied,
	input  logic                   rob_full,
	input  rob_tag_t               alloc_tag,
	output logic                   issue_fire,
	output wb_slot_t               book_slot,
	output logic [STAGE_WIDTH-1:0] book_depth
);

	int   lat;
	logic above_free;

	////////////////////////////////////////////////////////////
	// slot check
	////////////////////////////////////////////////////////////

	// the stage above the target shifts into it at this edge
	always_comb begin
		lat = fu_latency(issue_unit);
		if (lat >= LINE_DEPTH) begin
			above_free = 1'b1;
		end else begin
			above_free = !occupied[lat];
		end
	end

	// no issue while in reset
	assign issue_ready = rst_n && !rob_full && above_free;
	assign issue_fire  = issue_valid && issue_ready;

	////////////////////////////////////////////////////////////
	// booked entry
	////////////////////////////////////////////////////////////

	assign book_depth = STAGE_WIDTH'(lat - 1);

	always_comb begin
		book_slot.valid = issue_fire;
		book_slot.tag   = alloc_tag;
		book_slot.unit  = issue_unit;
		book_slot.data  = issue_data;
	end

	// longest unit has no stage above it, so only a full rob holds it back
	a_fdiv_never_refused: assert property (
		@(posedge clk) disable iff (!rst_n)
		issue_valid && issue_unit == FU_FDIV && !rob_full |-> issue_ready
	);

endmodule

// ==== verilog/wb_reservation_line.sv ====
`timescale 1ns/1ps

module wb_reservation_line
	import fu_pkg::*;
	import rob_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   book,
	input  wb_slot_t               book_slot,
	input  logic [STAGE_WIDTH-1:0] book_depth,
	output logic [LINE_DEPTH-1:0]  occupied,
	output logic                   cdb_valid,
	output rob_tag_t               cdb_tag,
	output wb_data_t               cdb_data
);

	logic [LINE_DEPTH-1:0] valid_q;
	wb_slot_t              line_q [LINE_DEPTH];
	wb_slot_t              line_d [LINE_DEPTH];
	logic                  shifted_hit;

	////////////////////////////////////////////////////////////
	// next line state
	////////////////////////////////////////////////////////////

	always_comb begin
		// everything moves one stage closer to the bus
		for (int i = 0; i < LINE_DEPTH - 1; i++) begin
			line_d[i]       = line_q[i+1];
			line_d[i].valid = valid_q[i+1];
		end
		line_d[LINE_DEPTH-1] = '0;

		// new booking lands on its target stage
		for (int i = 0; i < LINE_DEPTH; i++) begin
			if (book && book_depth == STAGE_WIDTH'(i)) begin
				line_d[i] = book_slot;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stages and broadcast register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= '0;
			cdb_valid <= 1'b0;
		end else begin
			for (int i = 0; i < LINE_DEPTH; i++) begin
				valid_q[i] <= line_d[i].valid;
			end
			cdb_valid <= valid_q[0];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < LINE_DEPTH; i++) begin
			line_q[i] <= line_d[i];
		end
		// bottom stage goes out on the bus
		cdb_tag  <= line_q[0].tag;
		cdb_data <= line_q[0].data;
	end

	assign occupied = valid_q;

	// entry that would shift into the booked stage
	assign shifted_hit = (book_depth != STAGE_WIDTH'(LINE_DEPTH - 1))
		&& valid_q[book_depth + 1'b1];

	a_no_slot_overwrite: assert property (
		@(posedge clk) disable iff (!rst_n)
		book |-> !shifted_hit
	);

endmodule

// ==== verilog/rob_completion.sv ====
`timescale 1ns/1ps

module rob_completion
	import rob_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     issue_fire,
	output rob_tag_t alloc_tag,
	output logic     rob_full,
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag,
	input  wb_data_t cdb_data,
	output logic     commit_req,
	output rob_tag_t commit_tag,
	output wb_data_t commit_data,
	input  logic     commit_ack
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_ACK_LOW
	} commit_state_t;

	commit_state_t        state_q;
	rob_tag_t             head_q;
	rob_tag_t             tail_q;
	logic [TAG_WIDTH:0]   count_q;
	logic [ROB_DEPTH-1:0] busy_q;
	logic [ROB_DEPTH-1:0] done_q;
	wb_data_t             data_q [ROB_DEPTH];
	logic                 head_ready;
	logic                 retire;

	assign alloc_tag = tail_q;
	assign rob_full  = count_q == (TAG_WIDTH+1)'(ROB_DEPTH);

	// head done already, or finishing on the bus right now
	assign head_ready = busy_q[head_q]
		&& (done_q[head_q] || (cdb_valid && cdb_tag == head_q));
	assign retire = state_q == ST_REQ && commit_ack;

	////////////////////////////////////////////////////////////
	// entry flags and pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			busy_q  <= '0;
			done_q  <= '0;
		end else begin
			if (retire) begin
				busy_q[head_q] <= 1'b0;
				head_q         <= head_q + 1'b1;
			end
			if (issue_fire) begin
				busy_q[tail_q] <= 1'b1;
				done_q[tail_q] <= 1'b0;
				tail_q         <= tail_q + 1'b1;
			end
			if (cdb_valid) begin
				done_q[cdb_tag] <= 1'b1;
			end
			count_q <= count_q + issue_fire - retire;
		end
	end

	always_ff @(posedge clk) begin
		if (cdb_valid) begin
			data_q[cdb_tag] <= cdb_data;
		end
	end

	////////////////////////////////////////////////////////////
	// four-phase commit of the head
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE:    if (head_ready && !commit_ack) state_q <= ST_REQ;
				ST_REQ:     if (commit_ack) state_q <= ST_ACK_LOW;
				ST_ACK_LOW: if (!commit_ack) state_q <= ST_IDLE;
				default:    state_q <= ST_IDLE;
			endcase
		end
	end

	assign commit_req  = state_q == ST_REQ;
	assign commit_tag  = head_q;
	assign commit_data = data_q[head_q];

	// broadcast only for an allocated entry still waiting
	a_cdb_hits_pending: assert property (
		@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> busy_q[cdb_tag] && !done_q[cdb_tag]
	);

	a_req_held_until_ack: assert property (
		@(posedge clk) disable iff (!rst_n)
		commit_req && !commit_ack |=> commit_req
	);

endmodule

// ==== verilog/fpu_writeback_core.sv ====
`timescale 1ns/1ps

module fpu_writeback_core
	import fu_pkg::*;
	import rob_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     issue_valid,
	input  fu_unit_t issue_unit,
	input  wb_data_t issue_data,
	output logic     issue_ready,
	output logic     cdb_valid,
	output rob_tag_t cdb_tag,
	output wb_data_t cdb_data,
	output logic     commit_req,
	output rob_tag_t commit_tag,
	output wb_data_t commit_data,
	input  logic     commit_ack
);

	logic [LINE_DEPTH-1:0]  occupied;
	logic                   issue_fire;
	wb_slot_t               book_slot;
	logic [STAGE_WIDTH-1:0] book_depth;
	logic                   rob_full;
	rob_tag_t               alloc_tag;

	wb_issue_arbiter i_wb_issue_arbiter (
		.clk, .rst_n,
		.issue_valid, .issue_unit, .issue_data, .issue_ready,
		.occupied, .rob_full, .alloc_tag,
		.issue_fire, .book_slot, .book_depth
	);

	// an accepted issue is the booking
	wb_reservation_line i_wb_reservation_line (
		.clk, .rst_n,
		.book(issue_fire), .book_slot, .book_depth,
		.occupied, .cdb_valid, .cdb_tag, .cdb_data
	);

	rob_completion i_rob_completion (
		.clk, .rst_n,
		.issue_fire, .alloc_tag, .rob_full,
		.cdb_valid, .cdb_tag, .cdb_data,
		.commit_req, .commit_tag, .commit_data, .commit_ack
	);

endmodule

// ==== verif/wb_case_table.svh ====
`ifndef WB_CASE_TABLE_SVH
`define WB_CASE_TABLE_SVH

// columns: unit, expected latency, payload, idle cycles before the row,
// ack delay for its commit, expected tag
localparam int CASE_COUNT = 26;

task automatic load_case_table();
	// one of each unit, fadd and fmul aimed at a slot booked by fdiv
	add_case(FU_FDIV, 14, 32'h3f80_0000, 0, 2, 4'd0);
	add_case(FU_FADD, 6, 32'h4000_0000, 7, 1, 4'd1);
	add_case(FU_FMUL, 4, 32'h4040_0000, 0, 0, 4'd2);
	add_case(FU_ITOF, 3, 32'h4080_0000, 0, 3, 4'd3);
	add_case(FU_LW, 1, 32'h40a0_0000, 2, 1, 4'd4);
	add_case(FU_FDIV, 14, 32'h40c0_0000, 0, 0, 4'd5);
	add_case(FU_FMUL, 4, 32'h40e0_0000, 9, 2, 4'd6);
	add_case(FU_LW, 1, 32'h4100_0000, 0, 1, 4'd7);
	// slow ack on this fdiv, lw burst behind it fills the rob
	add_case(FU_FDIV, 14, 32'h4110_0000, 3, 40, 4'd8);
	add_case(FU_LW, 1, 32'hc1d0_0009, 0, 1, 4'd9);
	add_case(FU_LW, 1, 32'hc1d0_000a, 0, 1, 4'd10);
	add_case(FU_LW, 1, 32'hc1d0_000b, 0, 1, 4'd11);
	add_case(FU_LW, 1, 32'hc1d0_000c, 0, 1, 4'd12);
	add_case(FU_LW, 1, 32'hc1d0_000d, 0, 1, 4'd13);
	add_case(FU_LW, 1, 32'hc1d0_000e, 0, 1, 4'd14);
	add_case(FU_LW, 1, 32'hc1d0_000f, 0, 1, 4'd15);
	add_case(FU_LW, 1, 32'hc1d0_0010, 0, 1, 4'd0);
	add_case(FU_LW, 1, 32'hc1d0_0011, 0, 1, 4'd1);
	add_case(FU_LW, 1, 32'hc1d0_0012, 0, 1, 4'd2);
	add_case(FU_LW, 1, 32'hc1d0_0013, 0, 1, 4'd3);
	add_case(FU_LW, 1, 32'hc1d0_0014, 0, 1, 4'd4);
	add_case(FU_LW, 1, 32'hc1d0_0015, 0, 1, 4'd5);
	add_case(FU_LW, 1, 32'hc1d0_0016, 0, 1, 4'd6);
	add_case(FU_LW, 1, 32'hc1d0_0017, 0, 1, 4'd7);
	add_case(FU_LW, 1, 32'hc1d0_0018, 0, 1, 4'd8);
	add_case(FU_FADD, 6, 32'h4120_0000, 1, 0, 4'd9);
endtask

`endif

// ==== verif/tb_fpu_writeback_core.sv ====
`timescale 1ns/1ps

module tb_fpu_writeback_core
	import fu_pkg::*;
	import rob_pkg::*;
();

	localparam logic [31:0] SEED = 32'hce2d9c7f;

	logic     clk;
	logic     rst_n;
	logic     issue_valid;
	fu_unit_t issue_unit;
	wb_data_t issue_data;
	logic     issue_ready;
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	wb_data_t cdb_data;
	logic     commit_req;
	rob_tag_t commit_tag;
	wb_data_t commit_data;
	logic     commit_ack;

	`include "wb_case_table.svh"

	fu_unit_t case_unit [CASE_COUNT];
	int       case_lat  [CASE_COUNT];
	wb_data_t case_data [CASE_COUNT];
	int       case_idle [CASE_COUNT];
	int       case_ack  [CASE_COUNT];
	rob_tag_t case_tag  [CASE_COUNT];
	int       case_fill = 0;
	int       max_ack   = 0;

	// reference model counts cycles in rising edges
	logic acc_valid [CASE_COUNT];
	int   bcast_cyc [CASE_COUNT];
	int   cycle_cnt   = 0;
	int   issued_cnt  = 0;
	int   retired_cnt = 0;
	int   cdb_seen    = 0;
	int   err_cnt     = 0;
	logic exp_valid;
	int   exp_idx;
	logic exp_ready;
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;

	fpu_writeback_core i_fpu_writeback_core (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic add_case(fu_unit_t unit, int lat, wb_data_t data, int idle, int ack,
			rob_tag_t tag);
		case_unit[case_fill] = unit;
		case_lat[case_fill]  = lat;
		case_data[case_fill] = data;
		case_idle[case_fill] = idle;
		case_ack[case_fill]  = ack;
		case_tag[case_fill]  = tag;
		if (ack > max_ack) max_ack = ack;
		case_fill++;
	endtask

	task automatic value_error(string name, logic [31:0] got, logic [31:0] want);
		$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
		err_cnt++;
	endtask

	task automatic event_error(string what);
		$display("failure at %0t: %s", $time, what);
		err_cnt++;
	endtask

	// rob has room and no earlier issue lands on the same broadcast cycle
	function automatic logic predict_ready(int row);
		int land;
		land = cycle_cnt + 1 + case_lat[row];
		if (issued_cnt - retired_cnt >= ROB_DEPTH) return 1'b0;
		for (int i = 0; i < issued_cnt; i++) begin
			if (bcast_cyc[i] == land) return 1'b0;
		end
		return 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue_unit  = FU_LW;
		issue_data  = '0;
		commit_ack  = 1'b0;
		for (int i = 0; i < CASE_COUNT; i++) begin
			acc_valid[i] = 1'b0;
			bcast_cyc[i] = 0;
		end
		load_case_table();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (issue_ready) else value_error("issue_ready", issue_ready, 1'b1);
		@(posedge clk);
		for (int r = 0; r < CASE_COUNT; r++) begin
			issue_valid <= 1'b0;
			repeat (case_idle[r]) @(posedge clk);
			issue_valid <= 1'b1;
			issue_unit  <= case_unit[r];
			issue_data  <= case_data[r];
			// hold the offer until the model says it is taken
			do begin
				@(negedge clk);
				exp_ready = predict_ready(r);
				assert (issue_ready == exp_ready)
					else value_error("issue_ready", issue_ready, exp_ready);
				if (exp_ready) begin
					acc_valid[r] = 1'b1;
					bcast_cyc[r] = cycle_cnt + 1 + case_lat[r];
					issued_cnt++;
				end
				@(posedge clk);
			end while (!exp_ready);
		end
		issue_valid <= 1'b0;
		while (retired_cnt < CASE_COUNT) @(negedge clk);
		repeat (3) @(negedge clk);
		assert (cdb_seen == CASE_COUNT) else event_error("an accepted issue was never broadcast");
		$display("issued %0d, broadcast %0d, committed %0d, errors %0d",
			issued_cnt, cdb_seen, retired_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////
	// broadcast and commit monitor
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!rst_n) begin
			if (cycle_cnt > 0) begin
				assert (!issue_ready) else value_error("issue_ready", issue_ready, 1'b0);
				assert (!cdb_valid) else value_error("cdb_valid", cdb_valid, 1'b0);
				assert (!commit_req) else value_error("commit_req", commit_req, 1'b0);
			end
		end else begin
			exp_valid = 1'b0;
			exp_idx   = 0;
			for (int i = 0; i < CASE_COUNT; i++) begin
				if (acc_valid[i] && bcast_cyc[i] == cycle_cnt) begin
					exp_valid = 1'b1;
					exp_idx   = i;
				end
			end
			assert (cdb_valid == exp_valid) else value_error("cdb_valid", cdb_valid, exp_valid);
			if (cdb_valid && exp_valid) begin
				cdb_seen++;
				assert (cdb_tag == case_tag[exp_idx])
					else value_error("cdb_tag", cdb_tag, case_tag[exp_idx]);
				assert (cdb_data == case_data[exp_idx])
					else value_error("cdb_data", cdb_data, case_data[exp_idx]);
			end
			// new request belongs to the oldest uncommitted issue
			if (commit_req && !prev_req) begin
				assert (!commit_ack) else event_error("commit_req rose while commit_ack was high");
				assert (acc_valid[retired_cnt] && bcast_cyc[retired_cnt] < cycle_cnt)
					else event_error("commit requested before the head was broadcast");
				assert (commit_tag == case_tag[retired_cnt])
					else value_error("commit_tag", commit_tag, case_tag[retired_cnt]);
				assert (commit_data == case_data[retired_cnt])
					else value_error("commit_data", commit_data, case_data[retired_cnt]);
			end
			if (!commit_req && prev_req) begin
				assert (prev_ack) else event_error("commit_req dropped before commit_ack rose");
			end
			if (commit_req && commit_ack) retired_cnt <= retired_cnt + 1;
			prev_req = commit_req;
			prev_ack = commit_ack;
		end
	end

	// four-phase commit responder
	initial begin
		void'($urandom(SEED));
		forever begin
			@(negedge clk);
			if (rst_n && commit_req) begin
				repeat (case_ack[retired_cnt] + $urandom % 3 + 1) @(posedge clk);
				commit_ack <= 1'b1;
				do @(negedge clk); while (commit_req);
				@(posedge clk);
				commit_ack <= 1'b0;
			end
		end
	end

	initial begin
		@(posedge rst_n);
		while (cycle_cnt < 10 + CASE_COUNT * (LAT_FDIV + max_ack + 4)) @(negedge clk);
		event_error("run did not finish within the cycle limit");
		$display("issued %0d, broadcast %0d, committed %0d, errors %0d",
			issued_cnt, cdb_seen, retired_cnt, err_cnt);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verif
verilog/fu_pkg.sv
verilog/rob_pkg.sv
verilog/wb_issue_arbiter.sv
verilog/wb_reservation_line.sv
verilog/rob_completion.sv
verilog/fpu_writeback_core.sv
verif/tb_fpu_writeback_core.sv

// ==== Bender.yml ====
package:
  name: fpu_writeback_core

sources:
  - verilog/fu_pkg.sv
  - verilog/rob_pkg.sv
  - verilog/wb_issue_arbiter.sv
  - verilog/wb_reservation_line.sv
  - verilog/rob_completion.sv
  - verilog/fpu_writeback_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_fpu_writeback_core.sv
